//--- design/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

`define DATA_W 32
`define REG_W  5

// Trap codes, 0 means no trap.
`define TRAP_SYSCALL 2'd1
`define TRAP_BREAK   2'd2
`define TRAP_ILLEGAL 2'd3

// ==============================
// Opcode and funct encodings
// ==============================
`define OP_RTYPE   6'h00
`define OP_ADDI    6'h08
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f

`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_SYSCALL 6'h0c
`define FN_BREAK   6'h0d
`define FN_ADD     6'h20
`define FN_SUB     6'h22
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a

`endif

//--- design/pipe_pkg.sv
`include "pipe_config.svh"

package pipe_pkg;

	// ==============================
	// Instruction word
	// ==============================
	typedef struct packed {
		logic [5:0]        opcode;
		logic [`REG_W-1:0] rs;
		logic [`REG_W-1:0] rt;
		logic [`REG_W-1:0] rd;
		logic [4:0]        shamt;
		logic [5:0]        funct;
	} r_form_t;

	typedef struct packed {
		logic [5:0]        opcode;
		logic [`REG_W-1:0] rs;
		logic [`REG_W-1:0] rt;
		logic [15:0]       imm;
	} i_form_t;

	// Same 32 bits, read by opcode.
	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} instr_word_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_lui
	} alu_op_t;

	// ==============================
	// Stage bundles
	// ==============================
	typedef struct packed {
		logic               valid;
		logic [`DATA_W-1:0] porta;
		logic [`DATA_W-1:0] portb;
		alu_op_t            alu_op;
		logic               we;
		logic [`REG_W-1:0]  waddr;
		logic               syscall_op;
		logic               break_op;
		logic               illegal_op;
	} idex_bundle_t;

	typedef struct packed {
		logic               wb_valid;
		logic [`REG_W-1:0]  waddr;
		logic [`DATA_W-1:0] wdata;
		logic               trap_valid;
		logic [1:0]         trap_code;
	} ex_result_t;

endpackage

//--- design/decode_stage.sv
`timescale 1ns/1ns
`include "pipe_config.svh"

module decode_stage (
	input  pipe_pkg::instr_word_t  instr,
	input  logic                   in_valid,
	input  logic [`DATA_W-1:0]     rs_val,
	input  logic [`DATA_W-1:0]     rt_val,
	output pipe_pkg::idex_bundle_t id_bundle
);

	logic [`DATA_W-1:0] shamt_ext;
	logic [`DATA_W-1:0] imm_sext;
	logic [`DATA_W-1:0] imm_zext;

	assign shamt_ext = {{(`DATA_W-5){1'b0}}, instr.r_form.shamt};
	assign imm_sext  = {{(`DATA_W-16){instr.i_form.imm[15]}}, instr.i_form.imm};
	assign imm_zext  = {{(`DATA_W-16){1'b0}}, instr.i_form.imm};

	always_comb begin
		id_bundle        = '0;
		id_bundle.valid  = in_valid;
		id_bundle.porta  = rs_val;
		id_bundle.portb  = rt_val;
		id_bundle.alu_op = pipe_pkg::alu_add;

		// ==============================
		// Register form
		// ==============================
		if (instr.r_form.opcode == `OP_RTYPE) begin
			id_bundle.waddr = instr.r_form.rd;
			id_bundle.we    = 1'b1;
			case (instr.r_form.funct)
				`FN_ADD: id_bundle.alu_op = pipe_pkg::alu_add;
				`FN_SUB: id_bundle.alu_op = pipe_pkg::alu_sub;
				`FN_AND: id_bundle.alu_op = pipe_pkg::alu_and;
				`FN_OR:  id_bundle.alu_op = pipe_pkg::alu_or;
				`FN_XOR: id_bundle.alu_op = pipe_pkg::alu_xor;
				`FN_SLT: id_bundle.alu_op = pipe_pkg::alu_slt;
				`FN_SLL: begin
					id_bundle.alu_op = pipe_pkg::alu_sll;
					id_bundle.portb  = shamt_ext; // Shift amount from the word.
				end
				`FN_SRL: begin
					id_bundle.alu_op = pipe_pkg::alu_srl;
					id_bundle.portb  = shamt_ext;
				end
				`FN_SYSCALL: begin
					id_bundle.we         = 1'b0;
					id_bundle.syscall_op = 1'b1;
				end
				`FN_BREAK: begin
					id_bundle.we       = 1'b0;
					id_bundle.break_op = 1'b1;
				end
				default: begin
					id_bundle.we         = 1'b0;
					id_bundle.illegal_op = 1'b1; // Unknown funct.
				end
			endcase
		end else begin
			// ==============================
			// Immediate form
			// ==============================
			id_bundle.waddr = instr.i_form.rt;
			id_bundle.we    = 1'b1;
			id_bundle.portb = imm_zext;
			case (instr.i_form.opcode)
				`OP_ADDI: begin
					id_bundle.alu_op = pipe_pkg::alu_add;
					id_bundle.portb  = imm_sext;
				end
				`OP_ANDI: id_bundle.alu_op = pipe_pkg::alu_and;
				`OP_ORI:  id_bundle.alu_op = pipe_pkg::alu_or;
				`OP_LUI:  id_bundle.alu_op = pipe_pkg::alu_lui;
				default: begin
					id_bundle.we         = 1'b0;
					id_bundle.illegal_op = 1'b1;
				end
			endcase
		end

		// Register 0 is never written.
		if (id_bundle.waddr == '0) begin
			id_bundle.we = 1'b0;
		end
	end

endmodule

//--- design/idex_reg.sv
`timescale 1ns/1ns

module idex_reg (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	input  logic                   flush,
	input  pipe_pkg::idex_bundle_t id_bundle,
	output pipe_pkg::idex_bundle_t ex_bundle
);

	// Flush wins over stall.
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_bundle <= '0;
		end else if (flush) begin
			ex_bundle <= '0; // Bubble.
		end else if (!stall) begin
			ex_bundle <= id_bundle;
		end
	end

	// ==============================
	// Checks
	// ==============================
	// Decode sets at most one trap source per instruction.
	a_one_trap: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0({ex_bundle.syscall_op, ex_bundle.break_op, ex_bundle.illegal_op})
	) else $error("ex_bundle carries more than one trap flag");

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ns
`include "pipe_config.svh"

module execute_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	input  pipe_pkg::idex_bundle_t ex_bundle,
	output logic                   flush,
	output pipe_pkg::ex_result_t   result
);

	logic [`DATA_W-1:0]   alu_out;
	logic [4:0]           sh;
	logic                 trap;
	pipe_pkg::ex_result_t next_result;

	assign sh = ex_bundle.portb[4:0];

	// ==============================
	// ALU
	// ==============================
	always_comb begin
		case (ex_bundle.alu_op)
			pipe_pkg::alu_add: alu_out = ex_bundle.porta + ex_bundle.portb;
			pipe_pkg::alu_sub: alu_out = ex_bundle.porta - ex_bundle.portb;
			pipe_pkg::alu_and: alu_out = ex_bundle.porta & ex_bundle.portb;
			pipe_pkg::alu_or:  alu_out = ex_bundle.porta | ex_bundle.portb;
			pipe_pkg::alu_xor: alu_out = ex_bundle.porta ^ ex_bundle.portb;
			pipe_pkg::alu_slt: begin
				alu_out = {{(`DATA_W-1){1'b0}},
					($signed(ex_bundle.porta) < $signed(ex_bundle.portb))};
			end
			pipe_pkg::alu_sll: alu_out = ex_bundle.porta << sh;
			pipe_pkg::alu_srl: alu_out = ex_bundle.porta >> sh;
			pipe_pkg::alu_lui: alu_out = ex_bundle.portb << 16;
			default:           alu_out = '0;
		endcase
	end

	// ==============================
	// Trap and result
	// ==============================
	assign trap  = ex_bundle.valid &&
		(ex_bundle.syscall_op || ex_bundle.break_op || ex_bundle.illegal_op);
	assign flush = trap && !stall; // Kills the instruction in decode.

	always_comb begin
		next_result = '0;
		if (ex_bundle.valid && !stall) begin
			if (trap) begin
				next_result.trap_valid = 1'b1;
				if (ex_bundle.syscall_op) begin
					next_result.trap_code = `TRAP_SYSCALL;
				end else if (ex_bundle.break_op) begin
					next_result.trap_code = `TRAP_BREAK;
				end else begin
					next_result.trap_code = `TRAP_ILLEGAL;
				end
			end else if (ex_bundle.we) begin
				next_result.wb_valid = 1'b1;
				next_result.waddr    = ex_bundle.waddr;
				next_result.wdata    = alu_out;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else begin
			result <= next_result;
		end
	end

	// ==============================
	// Checks
	// ==============================
	a_wb_xor_trap: assert property (
		@(posedge clk) disable iff (reset)
		!(result.wb_valid && result.trap_valid)
	) else $error("wb_valid and trap_valid both high");

	// The register upstream must have taken the bubble.
	a_flush_bubble: assert property (
		@(posedge clk) disable iff (reset)
		flush |=> !ex_bundle.valid
	) else $error("ex_bundle valid after flush");

endmodule

//--- design/pipe_top.sv
`timescale 1ns/1ns
`include "pipe_config.svh"

module pipe_top (
	input  logic                  clk,
	input  logic                  reset,
	input  pipe_pkg::instr_word_t instr,
	input  logic                  in_valid,
	input  logic [`DATA_W-1:0]    rs_val,
	input  logic [`DATA_W-1:0]    rt_val,
	input  logic                  stall,
	output pipe_pkg::ex_result_t  result,
	output logic                  flush
);

	pipe_pkg::idex_bundle_t id_bundle;
	pipe_pkg::idex_bundle_t ex_bundle;

	decode_stage u_decode (
		.instr     (instr),
		.in_valid  (in_valid),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.id_bundle (id_bundle)
	);

	idex_reg u_idex (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.flush     (flush),
		.id_bundle (id_bundle),
		.ex_bundle (ex_bundle)
	);

	execute_stage u_execute (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.ex_bundle (ex_bundle),
		.flush     (flush),
		.result    (result)
	);

endmodule

//--- testbench/pipe_tb.sv
`timescale 1ns/1ns
`include "pipe_config.svh"

module pipe_tb;

	localparam int MAX_TESTS = 128;
	localparam int DRAIN     = 4;   // Result latency is two edges, plus slack.
	localparam int MARGIN    = 20;

	typedef struct packed {
		int                   idx;
		int                   min_edge;
		pipe_pkg::ex_result_t res;
	} expect_t;

	logic                  clk = 1'b0;
	logic                  reset;
	pipe_pkg::instr_word_t instr;
	logic                  in_valid;
	logic [`DATA_W-1:0]    rs_val;
	logic [`DATA_W-1:0]    rt_val;
	logic                  stall;
	pipe_pkg::ex_result_t  result;
	logic                  flush;

	logic [31:0] test_mem [0:MAX_TESTS*5-1];
	logic [31:0] extra_stall [0:MAX_TESTS-1];
	expect_t     expected [$];
	int          n_tests = 0;
	int          limit = 0;
	int          cycles = 0;
	int          errors = 0;
	int          checked = 0;
	logic        stall_last = 1'b0;
	logic [31:0] rng;

	pipe_top dut_i (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.in_valid (in_valid),
		.rs_val   (rs_val),
		.rt_val   (rt_val),
		.stall    (stall),
		.result   (result),
		.flush    (flush)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ==============================
	// Reference model
	// ==============================
	function automatic pipe_pkg::ex_result_t model_result(input logic [31:0] w,
			input logic [31:0] a, input logic [31:0] b);
		pipe_pkg::ex_result_t r;
		logic [31:0] imm_s;
		logic [31:0] imm_z;
		logic [31:0] sh;
		r          = '0;
		imm_s      = {{16{w[15]}}, w[15:0]};
		imm_z      = {16'h0000, w[15:0]};
		sh         = {27'd0, w[10:6]};
		r.wb_valid = 1'b1;
		if (w[31:26] == `OP_RTYPE) begin
			r.waddr = w[15:11];
			case (w[5:0])
				`FN_ADD:     r.wdata = a + b;
				`FN_SUB:     r.wdata = a - b;
				`FN_AND:     r.wdata = a & b;
				`FN_OR:      r.wdata = a | b;
				`FN_XOR:     r.wdata = a ^ b;
				`FN_SLT:     r.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				`FN_SLL:     r.wdata = a << sh;
				`FN_SRL:     r.wdata = a >> sh;
				`FN_SYSCALL: r.trap_code = `TRAP_SYSCALL;
				`FN_BREAK:   r.trap_code = `TRAP_BREAK;
				default:     r.trap_code = `TRAP_ILLEGAL;
			endcase
		end else begin
			r.waddr = w[20:16];
			case (w[31:26])
				`OP_ADDI: r.wdata = a + imm_s;
				`OP_ANDI: r.wdata = a & imm_z;
				`OP_ORI:  r.wdata = a | imm_z;
				`OP_LUI:  r.wdata = {w[15:0], 16'h0000};
				default:  r.trap_code = `TRAP_ILLEGAL;
			endcase
		end
		if (r.trap_code != 2'd0) begin
			r.wb_valid   = 1'b0;
			r.trap_valid = 1'b1;
			r.waddr      = '0;
			r.wdata      = '0;
		end else if (r.waddr == '0) begin
			r.wb_valid = 1'b0; // Register 0 takes no writes.
		end
		return r;
	endfunction

	task automatic compare_field(input int idx, input string name,
			input logic [31:0] got, input logic [31:0] want, inout logic ok);
		assert (got === want) else begin
			$display("[ERROR] test %0d %s got %h expected %h", idx, name, got, want);
			errors++;
			ok = 1'b0;
		end
	endtask

	// ==============================
	// Result monitor
	// ==============================
	always @(posedge clk) begin : monitor
		expect_t e;
		logic    ok;
		if (result.wb_valid || result.trap_valid) begin
			assert (!stall_last) else begin
				$display("A result appeared although the cycle before it was stalled");
				errors++;
			end
			assert (expected.size() > 0) else begin
				$display("A result appeared with no expected entry left");
				errors++;
			end
			if (expected.size() > 0) begin
				e  = expected.pop_front();
				ok = 1'b1;
				assert (cycles >= e.min_edge) else begin
					$display("Test %0d gave its result before two edges had passed", e.idx);
					errors++;
					ok = 1'b0;
				end
				compare_field(e.idx, "result.wb_valid", 32'(result.wb_valid),
					32'(e.res.wb_valid), ok);
				compare_field(e.idx, "result.trap_valid", 32'(result.trap_valid),
					32'(e.res.trap_valid), ok);
				compare_field(e.idx, "result.trap_code", 32'(result.trap_code),
					32'(e.res.trap_code), ok);
				compare_field(e.idx, "result.waddr", 32'(result.waddr), 32'(e.res.waddr), ok);
				compare_field(e.idx, "result.wdata", result.wdata, e.res.wdata, ok);
				checked++;
				$display("Test %0d %s", e.idx, ok ? "passed" : "FAILED");
			end
		end
		stall_last = stall;
	end

	// Guard against a hung pipeline.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin : driver
		int                   stalls;
		int                   total_stall;
		logic [31:0]          w;
		logic                 lost;
		pipe_pkg::ex_result_t r;
		expect_t              e;
		reset    = 1'b1;
		instr    = '0;
		in_valid = 1'b0;
		rs_val   = '0;
		rt_val   = '0;
		stall    = 1'b0;
		rng      = 32'h2ef4_6598;
		$readmemh("testbench/pipe_tests.txt", test_mem);
		while (n_tests < MAX_TESTS && test_mem[n_tests*5] !== 32'hffff_ffff) begin
			n_tests++;
		end
		total_stall = 0;
		for (int t = 0; t < n_tests; t++) begin
			rng            = xorshift(rng);
			extra_stall[t] = (rng[5:4] == 2'b00) ? {30'd0, rng[1:0]} : 32'd0;
			total_stall   += int'(test_mem[t*5+3] + extra_stall[t]);
		end
		limit = 3 + n_tests + total_stall + DRAIN + MARGIN;
		$display("%0d tests read, %0d stall cycles, limit %0d cycles",
			n_tests, total_stall, limit);

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int t = 0; t < n_tests; t++) begin
			w        = test_mem[t*5];
			instr    = w;
			rs_val   = test_mem[t*5+1];
			rt_val   = test_mem[t*5+2];
			in_valid = 1'b1;
			stalls   = int'(test_mem[t*5+3] + extra_stall[t]);
			stall    = (stalls > 0);
			repeat (stalls) @(negedge clk); // Instruction held under stall.
			stall = 1'b0;
			lost  = (test_mem[t*5+4] != 32'd0);
			r     = model_result(w, rs_val, rt_val);
			if (lost) begin
				$display("Test %0d lost to a flush, no result expected", t);
			end else if (r.wb_valid || r.trap_valid) begin
				e.idx      = t;
				e.min_edge = cycles + 2;
				e.res      = r;
				expected.push_back(e);
			end else begin
				$display("Test %0d writes register 0, no result expected", t);
			end
			// Flush is high on the edge that would have taken a lost instruction.
			@(posedge clk);
			assert (flush === lost) else begin
				$display("[ERROR] test %0d flush got %h expected %h", t, flush, lost);
				errors++;
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
		instr    = '0;

		repeat (DRAIN) @(negedge clk);
		assert (expected.size() == 0) else begin
			$display("%0d expected results never appeared", expected.size());
			errors++;
		end
		$display("%0d tests, %0d results checked, %0d errors", n_tests, checked, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- testbench/pipe_tests.txt
// Columns: instr rs_val rt_val stall_cycles lost, all hex.
// lost = 1 marks the instruction killed by the flush of the trap before it.
// The all-ones line ends the list.
00221820 00000005 00000007 0 0 // add
00221820 ffffffff 00000001 0 0
00221822 00000010 00000003 0 0 // sub
00221822 00000000 00000001 1 0
00221824 f0f0f0f0 ff00ff00 0 0 // and
00221825 f0f0f0f0 0f0f0000 0 0 // or
00221826 aaaaaaaa 5555ffff 2 0 // xor
0022182a ffffffff 00000001 0 0 // slt
0022182a 00000001 ffffffff 0 0
0022182a 7fffffff 80000000 0 0
00222020 12345678 11111111 0 0
0022f820 00000100 00000200 0 0
00222900 00000003 00000000 0 0 // sll 4
00223202 80000000 00000000 0 0 // srl 8
00223fc0 00000001 00000000 1 0 // sll 31
00224002 deadbeef 00000000 0 0 // srl 0
2029fff0 00000020 00000000 0 0 // addi
20297fff 00000001 00000000 0 0
302aff00 12345678 00000000 0 0 // andi
342b8001 00000000 00000000 0 0 // ori
3c2cbeef 00000000 00000000 0 0 // lui
00220020 00000001 00000001 0 0 // add to r0
20200005 00000001 00000000 0 0 // addi to r0
00221820 00000001 00000001 0 0
0000000c 00000000 00000000 0 0 // syscall
00221820 00000001 00000001 0 1
00221822 00000009 00000004 0 0
0000000d 00000000 00000000 2 0 // break
00221824 ffffffff 0000ffff 3 1
00221825 00000001 00000002 0 0
8c221234 00000000 00000000 0 0 // lw, not decoded
00221826 00000003 00000005 0 1
00221822 00000003 00000005 0 0
0022183f 00000000 00000000 1 0 // bad funct
2029ffff 00000004 00000000 1 1
0022182a 80000000 00000001 0 0
0000000c 00000000 00000000 0 0
0000000d 00000000 00000000 0 1 // break lost behind syscall
0000000d 00000000 00000000 0 0
00220020 00000000 00000000 2 1
00221820 00000011 00000022 0 0
00221822 80000000 00000001 3 0
00221826 ffffffff ffffffff 0 0
00222900 ffffffff 00000000 2 0
3c2c0001 00000000 00000000 1 0
342b0000 12340000 00000000 0 0
2029fff0 00000005 00000000 1 0
302a00ff ffffffff 00000000 0 0
00223202 00000100 00000000 0 0
0022182a 00000005 00000005 0 0
0022182a 80000000 00000001 2 0
8c221234 00000000 00000000 2 0
3c2c8000 00000000 00000000 2 1
00221824 0000ffff 00ff00ff 0 0
00221825 00000000 00000000 1 0
ffffffff 00000000 00000000 0 0

//--- verilog.f
+incdir+design
design/pipe_pkg.sv
design/decode_stage.sv
design/idex_reg.sv
design/execute_stage.sv
design/pipe_top.sv
testbench/pipe_tb.sv

//--- Makefile
SIM  := obj_dir/pipe_sim
SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) verilog.f
	verilator --binary -j 0 -f verilog.f --top-module pipe_tb -o pipe_sim --Mdir obj_dir

run: $(SIM) testbench/pipe_tests.txt
	./$(SIM) | tee sim.log
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
